// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS = 100
) (
   output logic clk
);

   // Free-running, low at time zero
   initial begin
      clk = 1'b0;
   end

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: dv/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;
   import lsu_pkg::*;

   localparam int N_INSTR = 400;
   localparam int RUN_LIMIT = 20000;
   localparam int DRAIN_LIMIT = 200;
   localparam int MEM_BYTES = 65536;

   logic              clk;
   logic              rst;
   logic              instr_valid;
   logic [DATA_W-1:0] instr;
   logic              instr_ready;
   logic              dbus_cmd_valid;
   logic [DATA_W-1:0] dbus_cmd_addr;
   logic              dbus_cmd_we;
   logic [BE_W-1:0]   dbus_cmd_be;
   logic [DATA_W-1:0] dbus_cmd_wdata;
   logic              dbus_cmd_ready;
   logic              dbus_rsp_valid;
   logic [DATA_W-1:0] dbus_rsp_rdata;
   logic              wb_valid;
   logic [REG_AW-1:0] wb_reg;
   logic [DATA_W-1:0] wb_data;
   logic              exc_valid;
   logic [DATA_W-1:0] exc_vector;
   logic [DATA_W-1:0] exc_addr;

   // Program and reference state
   logic [31:0] lfsr;
   logic [31:0] prog [$];
   logic [31:0] ref_regs [NUM_REGS];
   logic [7:0]  ref_mem [MEM_BYTES];
   // Responder memory, updated only from observed stores
   logic [7:0]  bus_mem [MEM_BYTES];
   // Expected events, oldest first
   // wb entry is op, reg, data
   logic [39:0] exp_wb_q [$];
   // exc entry is op, vector, address
   logic [67:0] exp_exc_q [$];
   // cmd entry is addr, we, be, wdata
   logic [68:0] exp_cmd_q [$];

   // Per-cycle driver state
   int          idx;
   logic        took;
   logic        started;
   logic        hold;
   logic [68:0] held_cmd;
   logic        rsp_pending;
   int          rsp_wait;
   logic [31:0] rsp_addr;
   logic        timed_out;
   int          err_value;
   int          err_proto;
   int          err_timeout;

   tb_clock u_clock (
      .clk (clk)
   );

   lsu_top dut (.*);

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step for every bit taken
   function automatic logic [31:0] rnd(input int nbits);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Initial memory contents, every address bit takes part
   function automatic logic [7:0] fill_byte(input logic [15:0] a);
      return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h5a;
   endfunction

   function automatic int op_bytes(input logic [3:0] op);
      if (op inside {OP_LB, OP_LBU, OP_SB}) begin
         return 1;
      end else if (op inside {OP_LH, OP_LHU, OP_SH}) begin
         return 2;
      end
      return 4;
   endfunction

   function automatic string op_name(input logic [3:0] op);
      lsu_op_e e;
      e = lsu_op_e'(op);
      return e.name();
   endfunction

   function automatic logic [31:0] read_word(input logic [31:0] addr);
      logic [15:0] a;
      a = {addr[15:2], 2'b00};
      return {bus_mem[a + 3], bus_mem[a + 2], bus_mem[a + 1], bus_mem[a]};
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         err_value++;
      end
   endtask

   // Sequential reference, one instruction in program order
   task automatic model_exec(input logic [31:0] iw);
      logic [3:0]  op;
      logic [3:0]  rd;
      logic [31:0] imm;
      logic [31:0] ea;
      logic [31:0] src;
      logic [31:0] val;
      logic [31:0] wdata;
      logic [3:0]  be;
      int          nb;
      op = iw[31:28];
      rd = iw[27:24];
      imm = {{16{iw[15]}}, iw[15:0]};
      ea = ref_regs[iw[23:20]] + imm;
      src = ref_regs[iw[19:16]];
      nb = op_bytes(op);
      if (op == OP_LI) begin
         exp_wb_q.push_back({op, rd, imm});
         if (rd != 0) begin
            ref_regs[rd] = imm;
         end
      end else if (op >= OP_LB && op <= OP_SW) begin
         if (ea % nb != 0) begin
            exp_exc_q.push_back({op, VEC_MISALIGN, ea});
         end else if (ea >= DMEM_LIMIT) begin
            exp_exc_q.push_back({op, VEC_ACCESS, ea});
         end else begin
            be = '0;
            val = '0;
            for (int k = 0; k < nb; k++) begin
               be[ea[1:0] + k] = 1'b1;
            end
            // Low bytes of the source repeat across the word
            for (int lane = 0; lane < 4; lane++) begin
               wdata[8*lane +: 8] = src[8*(lane % nb) +: 8];
            end
            exp_cmd_q.push_back({ea, op >= OP_SB, be, wdata});
            for (int k = 0; k < nb; k++) begin
               if (op >= OP_SB) begin
                  ref_mem[ea + k] = src[8*k +: 8];
               end else begin
                  val[8*k +: 8] = ref_mem[ea + k];
               end
            end
            if (op < OP_SB) begin
               if (op == OP_LB && val[7]) begin
                  val[31:8] = '1;
               end
               if (op == OP_LH && val[15]) begin
                  val[31:16] = '1;
               end
               exp_wb_q.push_back({op, rd, val});
               if (rd != 0) begin
                  ref_regs[rd] = val;
               end
            end
         end
      end
   endtask

   task automatic add_instr(input logic [31:0] iw);
      prog.push_back(iw);
      model_exec(iw);
   endtask

   task automatic build_program();
      logic [3:0]  op;
      logic [3:0]  ld_op;
      logic [3:0]  rs1;
      logic [15:0] imm;
      int          m;
      // Bases inside the data window to start from
      for (int r = 1; r < NUM_REGS; r++) begin
         add_instr({OP_LI, 4'(r), 8'h00, 16'(rnd(11) << 4)});
      end
      for (int i = 0; i < N_INSTR; i++) begin
         op = 4'(rnd(4) % 10);
         m = rnd(3);
         // Periodic refresh of a base register
         if (i % 8 == 0) begin
            op = OP_LI;
            m = 1;
         end
         rs1 = 4'(rnd(4));
         if (op == OP_LI) begin
            imm = (m == 0) ? 16'(rnd(16)) : 16'(rnd(11) << 4);
         end else if (m == 0) begin
            // Wild offset, negative ones leave the window
            imm = 16'(rnd(16));
         end else if (m == 1) begin
            imm = 16'(rnd(8));
         end else begin
            imm = 16'(rnd(6) << 2);
         end
         add_instr({op, 4'(rnd(4)), rs1, 4'(rnd(4)), imm});
         // Read back the location just stored
         if ((op inside {OP_SB, OP_SH, OP_SW}) && rnd(1)) begin
            ld_op = (op == OP_SB) ? OP_LB : (op == OP_SH) ? OP_LHU : OP_LW;
            add_instr({ld_op, 4'(rnd(4)), rs1, 4'h0, imm});
         end
      end
   endtask

   // Drive on the falling edge, sample 20 ns later, well before the rising edge
   task automatic run_cycle();
      logic [68:0] cmd;
      logic [68:0] exp_cmd;
      logic [39:0] exp_wb;
      logic [67:0] exp_exc;
      logic [15:0] base;
      @(negedge clk);
      dbus_rsp_valid = 1'b0;
      if (rsp_pending) begin
         rsp_wait--;
         if (rsp_wait == 0) begin
            dbus_rsp_valid = 1'b1;
            dbus_rsp_rdata = read_word(rsp_addr);
            rsp_pending = 1'b0;
         end
      end
      dbus_cmd_ready = (rnd(2) != 0);
      // An offered instruction stays until accepted
      if (!instr_valid || took) begin
         instr_valid = (idx < prog.size()) && (rnd(2) != 0);
         if (instr_valid) begin
            instr = prog[idx];
         end
      end
      took = 1'b0;
      #20;
      if (!started && (wb_valid || exc_valid || dbus_cmd_valid)) begin
         $display("strobe or bus command active before the first instruction");
         err_proto++;
      end
      if (instr_valid && instr_ready) begin
         idx++;
         took = 1'b1;
         started = 1'b1;
      end
      cmd = {dbus_cmd_addr, dbus_cmd_we, dbus_cmd_be, dbus_cmd_wdata};
      if (hold && (!dbus_cmd_valid || cmd !== held_cmd)) begin
         $display("bus command dropped or changed while dbus_cmd_ready was low");
         err_proto++;
      end
      hold = dbus_cmd_valid && !dbus_cmd_ready;
      held_cmd = cmd;
      if (dbus_cmd_valid && dbus_cmd_ready) begin
         if (exp_cmd_q.size() == 0) begin
            $display("bus command issued with none expected");
            err_proto++;
         end else begin
            exp_cmd = exp_cmd_q.pop_front();
            check_value("cmd_addr", exp_cmd[68:37], dbus_cmd_addr);
            check_value("cmd_we", 32'(exp_cmd[36]), 32'(dbus_cmd_we));
            check_value("cmd_be", 32'(exp_cmd[35:32]), 32'(dbus_cmd_be));
            if (exp_cmd[36]) begin
               check_value("cmd_wdata", exp_cmd[31:0], dbus_cmd_wdata);
            end
         end
         base = {dbus_cmd_addr[15:2], 2'b00};
         if (dbus_cmd_we) begin
            for (int lane = 0; lane < 4; lane++) begin
               if (dbus_cmd_be[lane]) begin
                  bus_mem[base + lane] = dbus_cmd_wdata[8*lane +: 8];
               end
            end
         end else begin
            if (rsp_pending) begin
               $display("second load issued before the first was answered");
               err_proto++;
            end
            // Answer after 1 to 4 cycles
            rsp_pending = 1'b1;
            rsp_wait = 1 + rnd(2);
            rsp_addr = dbus_cmd_addr;
         end
      end
      if (wb_valid) begin
         if (exp_wb_q.size() == 0) begin
            $display("writeback strobe with none expected");
            err_proto++;
         end else begin
            exp_wb = exp_wb_q.pop_front();
            check_value({op_name(exp_wb[39:36]), " wb_reg"}, 32'(exp_wb[35:32]), 32'(wb_reg));
            check_value({op_name(exp_wb[39:36]), " wb_data"}, exp_wb[31:0], wb_data);
         end
      end
      if (exc_valid) begin
         if (exp_exc_q.size() == 0) begin
            $display("exception strobe with none expected");
            err_proto++;
         end else begin
            exp_exc = exp_exc_q.pop_front();
            check_value({op_name(exp_exc[67:64]), " exc_vector"}, exp_exc[63:32], exc_vector);
            check_value({op_name(exp_exc[67:64]), " exc_addr"}, exp_exc[31:0], exc_addr);
         end
      end
   endtask

   initial begin
      int cycles;
      rst = 1'b1;
      instr_valid = 1'b0;
      instr = '0;
      dbus_cmd_ready = 1'b0;
      dbus_rsp_valid = 1'b0;
      dbus_rsp_rdata = '0;
      lfsr = 32'h21b11241;
      idx = 0;
      took = 1'b0;
      started = 1'b0;
      hold = 1'b0;
      held_cmd = '0;
      rsp_pending = 1'b0;
      rsp_wait = 0;
      rsp_addr = '0;
      timed_out = 1'b0;
      err_value = 0;
      err_proto = 0;
      err_timeout = 0;
      for (int r = 0; r < NUM_REGS; r++) begin
         ref_regs[r] = '0;
      end
      for (int a = 0; a < MEM_BYTES; a++) begin
         ref_mem[a] = fill_byte(16'(a));
         bus_mem[a] = fill_byte(16'(a));
      end
      build_program();
      repeat (5) @(negedge clk);
      rst = 1'b0;
      // Feed the whole program
      cycles = 0;
      while (idx < prog.size() && !timed_out) begin
         run_cycle();
         cycles++;
         if (cycles > RUN_LIMIT) begin
            $display("timeout: program not accepted within %0d cycles", RUN_LIMIT);
            err_timeout++;
            timed_out = 1'b1;
         end
      end
      // Let outstanding results come back
      cycles = 0;
      while ((exp_wb_q.size() != 0 || exp_exc_q.size() != 0 || exp_cmd_q.size() != 0 ||
              rsp_pending) && !timed_out) begin
         run_cycle();
         cycles++;
         if (cycles > DRAIN_LIMIT) begin
            $display("timeout: results still missing after %0d cycles", DRAIN_LIMIT);
            err_timeout++;
            timed_out = 1'b1;
         end
      end
      // A few quiet cycles catch stray strobes
      if (!timed_out) begin
         repeat (4) run_cycle();
      end
      $display("errors: value %0d, protocol %0d, timeout %0d",
               err_value, err_proto, err_timeout);
      if (err_value + err_proto + err_timeout == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: lsu_top.f
source/lsu_pkg.sv
source/lsu_addr_check.sv
source/lsu_decode.sv
source/lsu_regfile.sv
source/lsu_execute.sv
source/lsu_result.sv
source/lsu_top.sv
dv/tb_clock.sv
dv/tb_lsu_top.sv

// File: source/lsu_addr_check.sv
`timescale 1ns/1ps

module lsu_addr_check (
   input  logic [lsu_pkg::DATA_W-1:0] addr,
   input  lsu_pkg::mem_size_e         size,
   output logic                       fault,
   output logic [lsu_pkg::DATA_W-1:0] vector
);
   import lsu_pkg::*;

   logic misalign;
   logic out_of_range;

   // Natural alignment per access size
   always_comb begin
      case (size)
         SIZE_HALF: misalign = addr[0];
         SIZE_WORD: misalign = (addr[1:0] != 2'b00);
         // Bytes are always aligned
         default:   misalign = 1'b0;
      endcase
   end

   // Outside the data window
   assign out_of_range = (addr >= DMEM_LIMIT);

   assign fault = misalign | out_of_range;

   // Misalignment wins over the range check
   always_comb begin
      if (misalign) begin
         vector = VEC_MISALIGN;
      end else if (out_of_range) begin
         vector = VEC_ACCESS;
      end else begin
         vector = '0;
      end
   end

endmodule

// File: source/lsu_decode.sv
`timescale 1ns/1ps

module lsu_decode (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       instr_valid,
   input  logic [lsu_pkg::DATA_W-1:0] instr,
   output logic                       instr_ready,
   input  logic                       ex_take,
   output logic                       dec_valid,
   output lsu_pkg::lsu_op_e           dec_op,
   output logic [lsu_pkg::REG_AW-1:0] dec_rd,
   output logic [lsu_pkg::DATA_W-1:0] dec_imm,
   output logic [lsu_pkg::REG_AW-1:0] rf_raddr1,
   output logic [lsu_pkg::REG_AW-1:0] rf_raddr2
);
   import lsu_pkg::*;

   logic [DATA_W-1:0] instr_q;
   lsu_op_e           in_op;
   logic              accept;
   logic              keep;

   // Free slot, or the held one leaves this cycle
   assign instr_ready = ~dec_valid | ex_take;
   assign accept = instr_valid & instr_ready;

   assign in_op = lsu_op_e'(instr[OP_LSB +: OP_W]);
   // NOP and unknown codes are swallowed at the port
   assign keep = (in_op != OP_NOP) && (in_op <= OP_LI);

   // Occupancy of the holding register
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else if (accept) begin
         dec_valid <= keep;
      end else if (ex_take) begin
         dec_valid <= 1'b0;
      end
   end

   // Instruction word itself
   always_ff @(posedge clk) begin
      if (accept && keep) begin
         instr_q <= instr;
      end
   end

   // Field split of the held word
   assign dec_op = lsu_op_e'(instr_q[OP_LSB +: OP_W]);
   assign dec_rd = instr_q[RD_LSB +: REG_AW];

   // Sign-extended offset or load-immediate value
   assign dec_imm = {{(DATA_W - IMM_W){instr_q[IMM_W-1]}}, instr_q[IMM_W-1:0]};

   // Base register and store data register
   assign rf_raddr1 = instr_q[RS1_LSB +: REG_AW];
   assign rf_raddr2 = instr_q[RS2_LSB +: REG_AW];

endmodule

// File: source/lsu_execute.sv
`timescale 1ns/1ps

module lsu_execute (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       dec_valid,
   input  lsu_pkg::lsu_op_e           dec_op,
   input  logic [lsu_pkg::REG_AW-1:0] dec_rd,
   input  logic [lsu_pkg::DATA_W-1:0] dec_imm,
   input  logic [lsu_pkg::DATA_W-1:0] rf_rdata1,
   input  logic [lsu_pkg::DATA_W-1:0] rf_rdata2,
   output logic                       ex_take,
   output logic                       dbus_cmd_valid,
   output logic [lsu_pkg::DATA_W-1:0] dbus_cmd_addr,
   output logic                       dbus_cmd_we,
   output logic [lsu_pkg::BE_W-1:0]   dbus_cmd_be,
   output logic [lsu_pkg::DATA_W-1:0] dbus_cmd_wdata,
   input  logic                       dbus_cmd_ready,
   input  logic                       dbus_rsp_valid,
   output logic                       ex_done_li,
   output logic                       ex_fault,
   output logic [lsu_pkg::DATA_W-1:0] ex_vector,
   output logic [lsu_pkg::DATA_W-1:0] ex_addr,
   output logic                       ex_load_issued,
   output logic [lsu_pkg::REG_AW-1:0] ex_rd,
   output lsu_pkg::mem_size_e         ex_size,
   output logic                       ex_sign,
   output logic [1:0]                 ex_lane,
   output logic [lsu_pkg::DATA_W-1:0] ex_imm
);
   import lsu_pkg::*;

   typedef enum logic {
      ST_IDLE,
      ST_LOAD_WAIT
   } state_e;

   state_e            state;
   state_e            state_nxt;
   logic              is_load;
   logic              is_store;
   logic              is_li;
   logic              sign;
   mem_size_e         size;
   logic [DATA_W-1:0] ea;
   logic              chk_fault;
   logic [DATA_W-1:0] chk_vector;
   logic              go;
   logic              cmd_hs;

   // Operation class
   assign is_load = dec_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
   assign is_store = dec_op inside {OP_SB, OP_SH, OP_SW};
   assign is_li = (dec_op == OP_LI);
   // Only LB and LH extend the sign bit
   assign sign = dec_op inside {OP_LB, OP_LH};

   always_comb begin
      case (dec_op)
         OP_LB, OP_LBU, OP_SB: size = SIZE_BYTE;
         OP_LH, OP_LHU, OP_SH: size = SIZE_HALF;
         default:              size = SIZE_WORD;
      endcase
   end

   // Effective address, base plus offset
   assign ea = rf_rdata1 + dec_imm;

   lsu_addr_check u_addr_check (
      .addr   (ea),
      .size   (size),
      .fault  (chk_fault),
      .vector (chk_vector)
   );

   // Lane enables and store data copied into every lane
   always_comb begin
      case (size)
         SIZE_BYTE: begin
            dbus_cmd_be    = 4'b0001 << ea[1:0];
            dbus_cmd_wdata = {4{rf_rdata2[7:0]}};
         end
         SIZE_HALF: begin
            dbus_cmd_be    = ea[1] ? 4'b1100 : 4'b0011;
            dbus_cmd_wdata = {2{rf_rdata2[15:0]}};
         end
         default: begin
            dbus_cmd_be    = '1;
            dbus_cmd_wdata = rf_rdata2;
         end
      endcase
   end

   // Nothing leaves decode while a load is outstanding
   assign go = dec_valid & (state == ST_IDLE);

   // Faulting accesses never reach the bus
   assign dbus_cmd_valid = go & (is_load | is_store) & ~chk_fault;
   assign dbus_cmd_addr = ea;
   assign dbus_cmd_we = is_store;
   assign cmd_hs = dbus_cmd_valid & dbus_cmd_ready;

   assign ex_done_li = go & is_li;
   assign ex_fault = go & (is_load | is_store) & chk_fault;
   assign ex_load_issued = cmd_hs & is_load;
   // LI and faults retire at once, memory ops at handshake
   assign ex_take = ex_done_li | ex_fault | cmd_hs;

   // Side info for result stage
   assign ex_vector = chk_vector;
   assign ex_addr = ea;
   assign ex_rd = dec_rd;
   assign ex_size = size;
   assign ex_sign = sign;
   assign ex_lane = ea[1:0];
   assign ex_imm = dec_imm;

   // Load-pending FSM
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (ex_load_issued) begin
               state_nxt = ST_LOAD_WAIT;
            end
         end
         ST_LOAD_WAIT: begin
            // Response lands, writeback follows on the same edge
            if (dbus_rsp_valid) begin
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

// File: source/lsu_pkg.sv
package lsu_pkg;

   // Datapath and address width
   localparam int DATA_W = 32;
   // Byte lanes per word
   localparam int BE_W = DATA_W / 8;

   // Register file geometry
   localparam int REG_AW = 4;
   localparam int NUM_REGS = 16;

   // Opcode field in bits 31:28
   localparam int OP_W = 4;
   localparam int OP_LSB = 28;

   // Operand fields
   localparam int RD_LSB = 24;
   localparam int RS1_LSB = 20;
   localparam int RS2_LSB = 16;
   // Signed immediate sits at 15:0
   localparam int IMM_W = 16;

   // Byte addresses at or above this fault
   localparam logic [DATA_W-1:0] DMEM_LIMIT = 32'h0001_0000;

   // Exception vectors
   localparam logic [DATA_W-1:0] VEC_MISALIGN = 32'h0000_0100;
   localparam logic [DATA_W-1:0] VEC_ACCESS = 32'h0000_0180;

   // Memory instruction opcodes
   typedef enum logic [OP_W-1:0] {
      OP_NOP = 4'd0,
      OP_LB  = 4'd1,
      OP_LBU = 4'd2,
      OP_LH  = 4'd3,
      OP_LHU = 4'd4,
      OP_LW  = 4'd5,
      OP_SB  = 4'd6,
      OP_SH  = 4'd7,
      OP_SW  = 4'd8,
      // Load-immediate, no memory traffic
      OP_LI  = 4'd9
   } lsu_op_e;

   // Access size
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } mem_size_e;

endpackage

// File: source/lsu_regfile.sv
`timescale 1ns/1ps

module lsu_regfile (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [lsu_pkg::REG_AW-1:0] raddr1,
   input  logic [lsu_pkg::REG_AW-1:0] raddr2,
   output logic [lsu_pkg::DATA_W-1:0] rdata1,
   output logic [lsu_pkg::DATA_W-1:0] rdata2,
   input  logic                       we,
   input  logic [lsu_pkg::REG_AW-1:0] waddr,
   input  logic [lsu_pkg::DATA_W-1:0] wdata
);
   import lsu_pkg::*;

   logic [DATA_W-1:0] regs [NUM_REGS];

   // Single write port, register 0 is hardwired
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // Asynchronous reads
   // Register 0 forced to zero on both ports
   always_comb begin
      if (raddr1 == '0) begin
         rdata1 = '0;
      end else begin
         rdata1 = regs[raddr1];
      end
   end

   always_comb begin
      if (raddr2 == '0) begin
         rdata2 = '0;
      end else begin
         rdata2 = regs[raddr2];
      end
   end

endmodule

// File: source/lsu_result.sv
`timescale 1ns/1ps

module lsu_result (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       ex_done_li,
   input  logic                       ex_fault,
   input  logic [lsu_pkg::DATA_W-1:0] ex_vector,
   input  logic [lsu_pkg::DATA_W-1:0] ex_addr,
   input  logic                       ex_load_issued,
   input  logic [lsu_pkg::REG_AW-1:0] ex_rd,
   input  lsu_pkg::mem_size_e         ex_size,
   input  logic                       ex_sign,
   input  logic [1:0]                 ex_lane,
   input  logic [lsu_pkg::DATA_W-1:0] ex_imm,
   input  logic                       dbus_rsp_valid,
   input  logic [lsu_pkg::DATA_W-1:0] dbus_rsp_rdata,
   output logic                       rf_we,
   output logic [lsu_pkg::REG_AW-1:0] rf_waddr,
   output logic [lsu_pkg::DATA_W-1:0] rf_wdata,
   output logic                       wb_valid,
   output logic [lsu_pkg::REG_AW-1:0] wb_reg,
   output logic [lsu_pkg::DATA_W-1:0] wb_data,
   output logic                       exc_valid,
   output logic [lsu_pkg::DATA_W-1:0] exc_vector,
   output logic [lsu_pkg::DATA_W-1:0] exc_addr
);
   import lsu_pkg::*;

   logic [REG_AW-1:0] ld_rd;
   mem_size_e         ld_size;
   logic              ld_sign;
   logic [1:0]        ld_lane;
   logic [7:0]        lane_b;
   logic [15:0]       lane_h;
   logic [DATA_W-1:0] ld_data;

   // Format of the outstanding load
   always_ff @(posedge clk) begin
      if (ex_load_issued) begin
         ld_rd   <= ex_rd;
         ld_size <= ex_size;
         ld_sign <= ex_sign;
         ld_lane <= ex_lane;
      end
   end

   // Pick the addressed lane out of the returned word
   assign lane_b = dbus_rsp_rdata[{ld_lane, 3'b000} +: 8];
   assign lane_h = ld_lane[1] ? dbus_rsp_rdata[DATA_W-1:16] : dbus_rsp_rdata[15:0];

   always_comb begin
      case (ld_size)
         SIZE_BYTE: ld_data = {{(DATA_W - 8){ld_sign & lane_b[7]}}, lane_b};
         SIZE_HALF: ld_data = {{(DATA_W - 16){ld_sign & lane_h[15]}}, lane_h};
         default:   ld_data = dbus_rsp_rdata;
      endcase
   end

   // LI and load responses never coincide
   assign rf_we = ex_done_li | dbus_rsp_valid;
   assign rf_waddr = ex_done_li ? ex_rd : ld_rd;
   assign rf_wdata = ex_done_li ? ex_imm : ld_data;

   // Strobes, one cycle each
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid  <= 1'b0;
         exc_valid <= 1'b0;
      end else begin
         wb_valid  <= rf_we;
         exc_valid <= ex_fault;
      end
   end

   // Strobe payloads
   always_ff @(posedge clk) begin
      wb_reg     <= rf_waddr;
      wb_data    <= rf_wdata;
      exc_vector <= ex_vector;
      exc_addr   <= ex_addr;
   end

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       instr_valid,
   input  logic [lsu_pkg::DATA_W-1:0] instr,
   output logic                       instr_ready,
   output logic                       dbus_cmd_valid,
   output logic [lsu_pkg::DATA_W-1:0] dbus_cmd_addr,
   output logic                       dbus_cmd_we,
   output logic [lsu_pkg::BE_W-1:0]   dbus_cmd_be,
   output logic [lsu_pkg::DATA_W-1:0] dbus_cmd_wdata,
   input  logic                       dbus_cmd_ready,
   input  logic                       dbus_rsp_valid,
   input  logic [lsu_pkg::DATA_W-1:0] dbus_rsp_rdata,
   output logic                       wb_valid,
   output logic [lsu_pkg::REG_AW-1:0] wb_reg,
   output logic [lsu_pkg::DATA_W-1:0] wb_data,
   output logic                       exc_valid,
   output logic [lsu_pkg::DATA_W-1:0] exc_vector,
   output logic [lsu_pkg::DATA_W-1:0] exc_addr
);
   import lsu_pkg::*;

   // Decode to execute
   logic              dec_valid;
   lsu_op_e           dec_op;
   logic [REG_AW-1:0] dec_rd;
   logic [DATA_W-1:0] dec_imm;
   logic              ex_take;

   // Register file ports
   logic [REG_AW-1:0] rf_raddr1;
   logic [REG_AW-1:0] rf_raddr2;
   logic [DATA_W-1:0] rf_rdata1;
   logic [DATA_W-1:0] rf_rdata2;
   logic              rf_we;
   logic [REG_AW-1:0] rf_waddr;
   logic [DATA_W-1:0] rf_wdata;

   // Execute to result
   logic              ex_done_li;
   logic              ex_fault;
   logic [DATA_W-1:0] ex_vector;
   logic [DATA_W-1:0] ex_addr;
   logic              ex_load_issued;
   logic [REG_AW-1:0] ex_rd;
   mem_size_e         ex_size;
   logic              ex_sign;
   logic [1:0]        ex_lane;
   logic [DATA_W-1:0] ex_imm;

   lsu_decode u_decode (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_ready (instr_ready),
      .ex_take     (ex_take),
      .dec_valid   (dec_valid),
      .dec_op      (dec_op),
      .dec_rd      (dec_rd),
      .dec_imm     (dec_imm),
      .rf_raddr1   (rf_raddr1),
      .rf_raddr2   (rf_raddr2)
   );

   lsu_regfile u_regfile (
      .clk    (clk),
      .rst    (rst),
      .raddr1 (rf_raddr1),
      .raddr2 (rf_raddr2),
      .rdata1 (rf_rdata1),
      .rdata2 (rf_rdata2),
      .we     (rf_we),
      .waddr  (rf_waddr),
      .wdata  (rf_wdata)
   );

   lsu_execute u_execute (
      .clk            (clk),
      .rst            (rst),
      .dec_valid      (dec_valid),
      .dec_op         (dec_op),
      .dec_rd         (dec_rd),
      .dec_imm        (dec_imm),
      .rf_rdata1      (rf_rdata1),
      .rf_rdata2      (rf_rdata2),
      .ex_take        (ex_take),
      .dbus_cmd_valid (dbus_cmd_valid),
      .dbus_cmd_addr  (dbus_cmd_addr),
      .dbus_cmd_we    (dbus_cmd_we),
      .dbus_cmd_be    (dbus_cmd_be),
      .dbus_cmd_wdata (dbus_cmd_wdata),
      .dbus_cmd_ready (dbus_cmd_ready),
      .dbus_rsp_valid (dbus_rsp_valid),
      .ex_done_li     (ex_done_li),
      .ex_fault       (ex_fault),
      .ex_vector      (ex_vector),
      .ex_addr        (ex_addr),
      .ex_load_issued (ex_load_issued),
      .ex_rd          (ex_rd),
      .ex_size        (ex_size),
      .ex_sign        (ex_sign),
      .ex_lane        (ex_lane),
      .ex_imm         (ex_imm)
   );

   lsu_result u_result (
      .clk            (clk),
      .rst            (rst),
      .ex_done_li     (ex_done_li),
      .ex_fault       (ex_fault),
      .ex_vector      (ex_vector),
      .ex_addr        (ex_addr),
      .ex_load_issued (ex_load_issued),
      .ex_rd          (ex_rd),
      .ex_size        (ex_size),
      .ex_sign        (ex_sign),
      .ex_lane        (ex_lane),
      .ex_imm         (ex_imm),
      .dbus_rsp_valid (dbus_rsp_valid),
      .dbus_rsp_rdata (dbus_rsp_rdata),
      .rf_we          (rf_we),
      .rf_waddr       (rf_waddr),
      .rf_wdata       (rf_wdata),
      .wb_valid       (wb_valid),
      .wb_reg         (wb_reg),
      .wb_data        (wb_data),
      .exc_valid      (exc_valid),
      .exc_vector     (exc_vector),
      .exc_addr       (exc_addr)
   );

endmodule
